// File: hdl/pic_pkg.sv
// Shared widths, register map and region encoding for the interrupt controller RTL
`default_nettype none

package pic_pkg;

  //////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////
  localparam int NUM_SRC      = 32;                // Slot 0 reserved
  localparam int SRC_IDX_BITS = $clog2(NUM_SRC);
  localparam int PRIO_BITS    = 4;
  localparam int ID_BITS      = 8;
  localparam int GWCFG_BITS   = 2;                 // Bit 0 polarity, bit 1 edge
  localparam int TREE_NODES   = 2 * NUM_SRC - 1;   // Leaves plus compare nodes
  localparam int REGION_LSB   = SRC_IDX_BITS + 2;  // Lowest address bit above the index

  localparam logic [PRIO_BITS-1:0] PRIO_MAX = '1;

  //////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////
  localparam logic [31:0] PIC_BASE_ADDR = 32'hf00c_0000;

  localparam logic [31:0] PRIO_OFFS   = 32'h0000_0000;
  localparam logic [31:0] PEND_OFFS   = 32'h0000_1000;  // One word
  localparam logic [31:0] ENABLE_OFFS = 32'h0000_2000;
  localparam logic [31:0] CONFIG_OFFS = 32'h0000_3000;  // One word
  localparam logic [31:0] GWCFG_OFFS  = 32'h0000_4000;
  localparam logic [31:0] GWCLR_OFFS  = 32'h0000_5000;  // Write only

  typedef enum logic [2:0] {
    REG_NONE,
    REG_PRIO,
    REG_PEND,
    REG_ENABLE,
    REG_CONFIG,
    REG_GWCFG,
    REG_GWCLR
  } pic_region_e;

endpackage

`default_nettype wire

// File: hdl/pic_cfg_if.sv
// Decoded register write and read accesses, from the address decoder to the register file
`timescale 1ns/10ps
`default_nettype none

interface pic_cfg_if import pic_pkg::*; ();

  logic                    wr_stb;     // One cycle per write
  pic_region_e             wr_region;
  logic [SRC_IDX_BITS-1:0] wr_idx;
  logic [31:0]             wr_data;

  logic                    rd_stb;
  pic_region_e             rd_region;
  logic [SRC_IDX_BITS-1:0] rd_idx;

  modport decode (
    output wr_stb, wr_region, wr_idx, wr_data,
    output rd_stb, rd_region, rd_idx
  );

  modport regs (
    input wr_stb, wr_region, wr_idx, wr_data,
    input rd_stb, rd_region, rd_idx
  );

endinterface

`default_nettype wire

// File: hdl/pic_reg_decode.sv
// Registers the memory-mapped access inputs and decodes each address into a region and index
`timescale 1ns/10ps
`default_nettype none

module pic_reg_decode import pic_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] picm_rdaddr,
  input  logic [31:0] picm_wraddr,
  input  logic [31:0] picm_wr_data,
  input  logic        picm_wren,
  input  logic        picm_rden,
  pic_cfg_if.decode   cfg
);

  logic [31:0] rdaddr_q;
  logic [31:0] wraddr_q;
  logic [31:0] wr_data_q;
  logic        wren_q;
  logic        rden_q;

  // Per-source regions match on the bits above the index
  function automatic logic in_region(input logic [31:0] addr, input logic [31:0] offs);
    logic [31:0] base;
    base = PIC_BASE_ADDR + offs;
    return addr[31:REGION_LSB] == base[31:REGION_LSB];
  endfunction

  function automatic pic_region_e decode_region(input logic [31:0] addr);
    pic_region_e region;
    region = REG_NONE;
    if (addr == PIC_BASE_ADDR + PEND_OFFS)        region = REG_PEND;
    else if (addr == PIC_BASE_ADDR + CONFIG_OFFS) region = REG_CONFIG;
    else if (in_region(addr, PRIO_OFFS))          region = REG_PRIO;
    else if (in_region(addr, ENABLE_OFFS))        region = REG_ENABLE;
    else if (in_region(addr, GWCFG_OFFS))         region = REG_GWCFG;
    else if (in_region(addr, GWCLR_OFFS))         region = REG_GWCLR;
    return region;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wren_q <= 1'b0;
      rden_q <= 1'b0;
    end else begin
      wren_q <= picm_wren;
      rden_q <= picm_rden;
    end
  end

  always_ff @(posedge clk) begin
    rdaddr_q  <= picm_rdaddr;
    wraddr_q  <= picm_wraddr;
    wr_data_q <= picm_wr_data;
  end

  assign cfg.wr_stb    = wren_q;
  assign cfg.wr_region = decode_region(wraddr_q);
  assign cfg.wr_idx    = wraddr_q[REGION_LSB-1:2];
  assign cfg.wr_data   = wr_data_q;

  assign cfg.rd_stb    = rden_q;
  assign cfg.rd_region = decode_region(rdaddr_q);
  assign cfg.rd_idx    = rdaddr_q[REGION_LSB-1:2];

endmodule

`default_nettype wire

// File: hdl/pic_reg_file.sv
// Configuration registers of the controller: priority, enable, gateway setup, order bit and read mux
`timescale 1ns/10ps
`default_nettype none

module pic_reg_file import pic_pkg::*; (
  input  logic                              clk,
  input  logic                              arst_n,
  pic_cfg_if.regs                           cfg,
  input  logic [NUM_SRC-1:0]                req_gw,
  output logic [NUM_SRC-1:0]                enable,
  output logic [NUM_SRC-1:0][PRIO_BITS-1:0] prio,
  output logic [NUM_SRC-1:0]                gw_polarity,
  output logic [NUM_SRC-1:0]                gw_edge,
  output logic [NUM_SRC-1:0]                gw_clear,
  output logic                              priord,
  output logic [31:0]                       picm_rd_data
);

  logic [NUM_SRC-1:0][PRIO_BITS-1:0]  prio_q;
  logic [NUM_SRC-1:0]                 en_q;
  logic [NUM_SRC-1:0][GWCFG_BITS-1:0] gwcfg_q;
  logic                               config_q;
  logic                               src_wr;

  // Slot 0 is never written, so it stays at its reset value
  assign src_wr = cfg.wr_stb && (cfg.wr_idx != '0);

  //////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prio_q   <= '0;
      en_q     <= '0;
      gwcfg_q  <= '0;
      config_q <= 1'b0;
    end else if (cfg.wr_stb) begin
      case (cfg.wr_region)
        REG_PRIO:   if (src_wr) prio_q[cfg.wr_idx] <= cfg.wr_data[PRIO_BITS-1:0];
        REG_ENABLE: if (src_wr) en_q[cfg.wr_idx] <= cfg.wr_data[0];
        REG_GWCFG:  if (src_wr) gwcfg_q[cfg.wr_idx] <= cfg.wr_data[GWCFG_BITS-1:0];
        REG_CONFIG: config_q <= cfg.wr_data[0];   // Single word at index 0
        default: ;
      endcase
    end
  end

  // Gateway clear pulses in the cycle of the write
  always_comb begin
    gw_clear = '0;
    if (src_wr && cfg.wr_region == REG_GWCLR) begin
      gw_clear[cfg.wr_idx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Configuration outputs
  //////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      gw_polarity[i] = gwcfg_q[i][0];
      gw_edge[i]     = gwcfg_q[i][1];
    end
  end

  assign enable = en_q;
  assign prio   = prio_q;
  assign priord = config_q;

  //////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////
  always_comb begin
    picm_rd_data = '0;
    if (cfg.rd_stb) begin
      case (cfg.rd_region)
        REG_PRIO:   picm_rd_data = 32'(prio_q[cfg.rd_idx]);
        REG_PEND:   picm_rd_data = 32'(req_gw);   // Bit i is source i
        REG_ENABLE: picm_rd_data = 32'(en_q[cfg.rd_idx]);
        REG_CONFIG: picm_rd_data = 32'(config_q);
        REG_GWCFG:  picm_rd_data = 32'(gwcfg_q[cfg.rd_idx]);
        default: ;                                 // GWCLR reads back zero
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/pic_gateway.sv
// One interrupt source gateway: two-flop synchronizer, polarity select and edge pending flop
`timescale 1ns/10ps
`default_nettype none

module pic_gateway (
  input  logic clk,
  input  logic arst_n,
  input  logic req,
  input  logic polarity,    // 1 for active low
  input  logic edge_mode,
  input  logic clear,
  output logic req_gw
);

  logic [1:0] sync_q;
  logic       active;
  logic       pend_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;
      pend_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], req};
      pend_q <= (edge_mode & active) | (pend_q & ~clear);  // Set wins over clear
    end
  end

  assign active = sync_q[1] ^ polarity;
  assign req_gw = active | (edge_mode & pend_q);

endmodule

`default_nettype wire

// File: hdl/pic_priority_tree.sv
// Masks the gateway requests and picks the source with the highest effective priority
`timescale 1ns/10ps
`default_nettype none

module pic_priority_tree import pic_pkg::*; (
  input  logic [NUM_SRC-1:0]                req_gw,
  input  logic [NUM_SRC-1:0]                enable,
  input  logic [NUM_SRC-1:0][PRIO_BITS-1:0] prio,
  input  logic                              priord,
  output logic [ID_BITS-1:0]                win_id,
  output logic [PRIO_BITS-1:0]              win_prio
);

  // Heap order: node n has children 2n+1 and 2n+2, leaves start at NUM_SRC-1
  logic [TREE_NODES-1:0][PRIO_BITS-1:0] node_prio;
  logic [TREE_NODES-1:0][ID_BITS-1:0]   node_id;

  //////////////////////////////////////////////////////////////
  // Leaves
  //////////////////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_SRC; i++) begin : g_leaf
    logic [PRIO_BITS-1:0] eff_prio;

    assign eff_prio = priord ? ~prio[i] : prio[i];
    assign node_prio[NUM_SRC-1+i] = (req_gw[i] & enable[i]) ? eff_prio : '0;
    assign node_id[NUM_SRC-1+i]   = ID_BITS'(i);
  end

  //////////////////////////////////////////////////////////////
  // Compare and select nodes
  //////////////////////////////////////////////////////////////
  for (genvar n = 0; n < NUM_SRC - 1; n++) begin : g_node
    logic left_lt_right;

    // Left subtree holds the lower ids, so a tie keeps the lower id
    assign left_lt_right = node_prio[2*n+1] < node_prio[2*n+2];
    assign node_prio[n]  = left_lt_right ? node_prio[2*n+2] : node_prio[2*n+1];
    assign node_id[n]    = left_lt_right ? node_id[2*n+2] : node_id[2*n+1];
  end

  assign win_id   = node_id[0];
  assign win_prio = node_prio[0];   // Effective domain

endmodule

`default_nettype wire

// File: hdl/pic_claim.sv
// Threshold check of the winning source and the registered claim, level and wake-up outputs
`timescale 1ns/10ps
`default_nettype none

module pic_claim import pic_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [ID_BITS-1:0]   win_id,
  input  logic [PRIO_BITS-1:0] win_prio,
  input  logic                 priord,
  input  logic [PRIO_BITS-1:0] meipt,
  input  logic [PRIO_BITS-1:0] meicurpl,
  output logic                 mexintpend,
  output logic [ID_BITS-1:0]   claimid,
  output logic [PRIO_BITS-1:0] pl,
  output logic                 mhwakeup
);

  logic [PRIO_BITS-1:0] meipt_eff;
  logic [PRIO_BITS-1:0] curpl_eff;
  logic [PRIO_BITS-1:0] pl_nxt;
  logic [PRIO_BITS-1:0] wake_lvl;
  logic                 pend_nxt;

  assign meipt_eff = priord ? ~meipt : meipt;
  assign curpl_eff = priord ? ~meicurpl : meicurpl;
  assign pend_nxt  = (win_prio > meipt_eff) && (win_prio > curpl_eff);

  assign pl_nxt   = priord ? ~win_prio : win_prio;   // Back to programmed value
  assign wake_lvl = priord ? '0 : PRIO_MAX;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mexintpend <= 1'b0;
      claimid    <= '0;
      pl         <= '0;
      mhwakeup   <= 1'b0;
    end else begin
      mexintpend <= pend_nxt;
      claimid    <= win_id;
      pl         <= pl_nxt;
      mhwakeup   <= (pl_nxt == wake_lvl);
    end
  end

endmodule

`default_nettype wire

// File: hdl/pic_ctrl.sv
// Top level of the single-hart interrupt controller, joining decoder, registers, gateways and tree
`timescale 1ns/10ps
`default_nettype none

module pic_ctrl import pic_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [NUM_SRC-1:0]   extintsrc_req,
  input  logic [31:0]          picm_rdaddr,
  input  logic [31:0]          picm_wraddr,
  input  logic [31:0]          picm_wr_data,
  input  logic                 picm_wren,
  input  logic                 picm_rden,
  input  logic [PRIO_BITS-1:0] meicurpl,
  input  logic [PRIO_BITS-1:0] meipt,
  output logic                 mexintpend,
  output logic [ID_BITS-1:0]   claimid,
  output logic [PRIO_BITS-1:0] pl,
  output logic                 mhwakeup,
  output logic [31:0]          picm_rd_data
);

  logic [NUM_SRC-1:0]                enable;
  logic [NUM_SRC-1:0][PRIO_BITS-1:0] prio;
  logic [NUM_SRC-1:0]                gw_polarity;
  logic [NUM_SRC-1:0]                gw_edge;
  logic [NUM_SRC-1:0]                gw_clear;
  logic [NUM_SRC-1:0]                req_gw;
  logic                              priord;
  logic [ID_BITS-1:0]                win_id;
  logic [PRIO_BITS-1:0]              win_prio;

  pic_cfg_if cfg_bus ();

  pic_reg_decode u_decode (.clk, .arst_n, .picm_rdaddr, .picm_wraddr, .picm_wr_data,
                           .picm_wren, .picm_rden, .cfg(cfg_bus));

  pic_reg_file u_regs (.clk, .arst_n, .cfg(cfg_bus), .req_gw, .enable, .prio, .gw_polarity,
                       .gw_edge, .gw_clear, .priord, .picm_rd_data);

  //////////////////////////////////////////////////////////////
  // Gateways
  //////////////////////////////////////////////////////////////
  assign req_gw[0] = 1'b0;   // Reserved slot

  for (genvar i = 1; i < NUM_SRC; i++) begin : g_gw
    pic_gateway u_gw (
      .clk,
      .arst_n,
      .req      (extintsrc_req[i]),
      .polarity (gw_polarity[i]),
      .edge_mode(gw_edge[i]),
      .clear    (gw_clear[i]),
      .req_gw   (req_gw[i])
    );
  end

  pic_priority_tree u_tree (.req_gw, .enable, .prio, .priord, .win_id, .win_prio);

  pic_claim u_claim (.clk, .arst_n, .win_id, .win_prio, .priord, .meipt, .meicurpl,
                     .mexintpend, .claimid, .pl, .mhwakeup);

endmodule

`default_nettype wire

// File: dv/pic_tb_clkgen.sv
// Testbench clock and reset source, a 4 ns clock with reset held low for the first 10 cycles
`timescale 1ns/10ps
`default_nettype none

module pic_tb_clkgen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/pic_ctrl_tb.sv
// Self-checking testbench of the interrupt controller, run as the simulation top with pic_tb_clkgen
`timescale 1ns/10ps
`default_nettype none

module pic_ctrl_tb import pic_pkg::*; ();

  localparam int MAX_CYCLES = 20000;   // All tests take about 4000 cycles

  logic clk, arst_n, picm_wren, picm_rden, mexintpend, mhwakeup;
  logic [NUM_SRC-1:0] extintsrc_req;
  logic [31:0] picm_rdaddr, picm_wraddr, picm_wr_data, picm_rd_data;
  logic [PRIO_BITS-1:0] meicurpl, meipt, pl;
  logic [ID_BITS-1:0] claimid;

  // Register and gateway model
  logic [PRIO_BITS-1:0] cfg_prio [NUM_SRC];
  logic [1:0] cfg_gw [NUM_SRC];   // Bit 0 polarity, bit 1 edge
  logic [NUM_SRC-1:0] cfg_en, edge_pend, gw_level;
  logic cfg_order, exp_pend, exp_wake, outputs_ok;
  logic [PRIO_BITS-1:0] exp_pl;
  logic [ID_BITS-1:0] exp_id;

  int stim_cnt = 0, stim_seen = 0, quiet = 0, cycles = 0;
  int out_fails = 0, rd_fails = 0, tests_run = 0, tests_failed = 0;

  pic_tb_clkgen u_clkgen (.clk, .arst_n);
  pic_ctrl UUT (.*);

  //////////////////////////////////////////////////////////////
  // Expected outputs
  //////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      gw_level[i] = (i != 0) && ((extintsrc_req[i] ^ cfg_gw[i][0]) || (cfg_gw[i][1] && edge_pend[i]));
    end
  end

  always_comb begin
    logic [PRIO_BITS-1:0] best, val, ipt_eff, cpl_eff;
    best   = '0;
    exp_id = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      val = cfg_order ? ~cfg_prio[i] : cfg_prio[i];
      if (gw_level[i] && cfg_en[i] && val > best) begin   // Strictly greater keeps the lower id
        best   = val;
        exp_id = ID_BITS'(i);
      end
    end
    ipt_eff    = cfg_order ? ~meipt : meipt;
    cpl_eff    = cfg_order ? ~meicurpl : meicurpl;
    exp_pend   = (best > ipt_eff) && (best > cpl_eff);
    exp_pl     = cfg_order ? ~best : best;
    exp_wake   = exp_pl == (cfg_order ? 4'h0 : 4'hf);
    outputs_ok = (mexintpend == exp_pend) && (mhwakeup == exp_wake) &&
                 (!exp_pend || (claimid == exp_id && pl == exp_pl));
  end

  // Edges since the last stimulus change
  always @(posedge clk) begin
    if (stim_cnt != stim_seen) begin
      stim_seen <= stim_cnt;
      quiet     <= 0;
    end else if (quiet < 100) begin
      quiet <= quiet + 1;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
                   (stim_cnt == stim_seen && quiet >= 2) |-> outputs_ok)
    else begin
      out_fails++;
      $display("MISMATCH at %0t: pend %b id %0d pl %0d wake %b, expected %b %0d %0d %b",
               $time, mexintpend, claimid, pl, mhwakeup, exp_pend, exp_id, exp_pl, exp_wake);
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic wait_settle();
    repeat (6) next_cycle();
  endtask

  task automatic latch_edges();
    for (int i = 1; i < NUM_SRC; i++) begin
      if (cfg_gw[i][1] && (extintsrc_req[i] ^ cfg_gw[i][0])) edge_pend[i] = 1'b1;
    end
  endtask

  task automatic drive_sources(input logic [NUM_SRC-1:0] req);
    extintsrc_req = req;
    latch_edges();
    stim_cnt++;
  endtask

  task automatic set_thresholds(input logic [PRIO_BITS-1:0] ipt, input logic [PRIO_BITS-1:0] cpl);
    meipt    = ipt;
    meicurpl = cpl;
    stim_cnt++;
  endtask

  task automatic write_reg(input logic [31:0] offs, input int idx, input logic [31:0] data);
    picm_wraddr  = PIC_BASE_ADDR + offs + 32'(4 * idx);
    picm_wr_data = data;
    picm_wren    = 1'b1;
    if (idx != 0) begin
      case (offs)
        PRIO_OFFS:   cfg_prio[idx] = data[PRIO_BITS-1:0];
        ENABLE_OFFS: cfg_en[idx] = data[0];
        GWCFG_OFFS:  cfg_gw[idx] = data[1:0];
        GWCLR_OFFS:  edge_pend[idx] = 1'b0;
        default: ;
      endcase
    end else if (offs == CONFIG_OFFS) begin
      cfg_order = data[0];
    end
    latch_edges();   // A still active edge source sets again
    stim_cnt++;
    next_cycle();
    picm_wren = 1'b0;
    stim_cnt++;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
    picm_rdaddr = addr;
    picm_rden   = 1'b1;
    next_cycle();
    picm_rden = 1'b0;
    #0.5;
    assert (picm_rd_data == exp) else begin
      rd_fails++;
      $display("MISMATCH at %0t: read of %h gave %h, expected %h", $time, addr, picm_rd_data, exp);
    end
    next_cycle();
    assert (picm_rd_data == '0) else begin
      rd_fails++;
      $display("MISMATCH at %0t: read data %h with no read active", $time, picm_rd_data);
    end
  endtask

  task automatic check_reg(input logic [31:0] offs, input int idx);
    logic [31:0] exp;
    exp = '0;
    case (offs)
      PRIO_OFFS:   exp = 32'(cfg_prio[idx]);
      ENABLE_OFFS: exp = 32'(cfg_en[idx]);
      GWCFG_OFFS:  exp = 32'(cfg_gw[idx]);
      PEND_OFFS:   exp = (idx == 0) ? gw_level : '0;   // Single word
      CONFIG_OFFS: exp = (idx == 0) ? 32'(cfg_order) : '0;
      default: ;
    endcase
    read_check(PIC_BASE_ADDR + offs + 32'(4 * idx), exp);
  endtask

  task automatic clear_config();
    drive_sources('0);
    for (int i = 1; i < NUM_SRC; i++) begin
      write_reg(GWCFG_OFFS, i, '0);
      write_reg(PRIO_OFFS, i, '0);
      write_reg(ENABLE_OFFS, i, '0);
      write_reg(GWCLR_OFFS, i, '0);
    end
    write_reg(CONFIG_OFFS, 0, '0);
  endtask

  task automatic report_test(input string name, input int fails_before);
    int fails;
    fails = out_fails + rd_fails - fails_before;
    tests_run++;
    if (fails != 0) tests_failed++;
    $display("Test %0d, %s: %0d mismatches", tests_run, name, fails);
  endtask

  //////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////
  initial begin
    int base, idx, hi;
    logic [31:0] offs;
    void'($urandom(78));
    {extintsrc_req, picm_rdaddr, picm_wraddr, picm_wr_data} = '0;
    {picm_wren, picm_rden, meicurpl, meipt} = '0;
    for (int i = 0; i < NUM_SRC; i++) begin
      cfg_prio[i] = '0;
      cfg_gw[i]   = '0;
    end
    {cfg_en, edge_pend, cfg_order} = '0;
    @(posedge arst_n);
    next_cycle();

    base = out_fails + rd_fails;
    for (int i = 0; i < NUM_SRC; i++) begin
      check_reg(PRIO_OFFS, i);
      check_reg(ENABLE_OFFS, i);
      check_reg(GWCFG_OFFS, i);
    end
    check_reg(PEND_OFFS, 0);
    check_reg(CONFIG_OFFS, 0);
    for (int n = 0; n < 40; n++) begin
      idx = $urandom_range(0, 31);
      case ($urandom_range(0, 3))
        0: offs = PRIO_OFFS;
        1: offs = ENABLE_OFFS;
        2: offs = GWCFG_OFFS;
        default: begin
          offs = CONFIG_OFFS;
          idx  = 0;
        end
      endcase
      write_reg(offs, idx, $urandom);
      check_reg(offs, idx);
    end
    read_check(PIC_BASE_ADDR + 32'h6000, '0);
    read_check(PIC_BASE_ADDR + PRIO_OFFS + 32'h80, '0);
    read_check(PIC_BASE_ADDR + PEND_OFFS + 32'h4, '0);
    read_check(PIC_BASE_ADDR + GWCLR_OFFS + 32'h8, '0);
    clear_config();
    report_test("register access", base);

    base = out_fails + rd_fails;
    set_thresholds(4'd2, 4'd1);
    for (int n = 0; n < 4; n++) begin
      idx = $urandom_range(1, 31);
      write_reg(PRIO_OFFS, idx, $urandom_range(3, 15));
      write_reg(ENABLE_OFFS, idx, 32'd1);
      drive_sources(NUM_SRC'(1) << idx);
      wait_settle();
      drive_sources('0);
      wait_settle();
      drive_sources(NUM_SRC'(1) << idx);
      wait_settle();
      write_reg(ENABLE_OFFS, idx, 32'd0);   // Disable drops the interrupt
      wait_settle();
      drive_sources('0);
    end
    clear_config();
    report_test("level interrupts", base);

    base = out_fails + rd_fails;
    for (int i = 1; i < NUM_SRC; i++) write_reg(ENABLE_OFFS, i, 32'($urandom_range(0, 5) != 0));
    for (int n = 0; n < 24; n++) begin
      hi = (n % 2 == 0) ? 15 : 3;   // Narrow range makes ties common
      for (int i = 1; i < NUM_SRC; i++) write_reg(PRIO_OFFS, i, $urandom_range(0, hi));
      for (int k = 0; k < 3; k++) begin
        drive_sources((k == 0) ? ($urandom & $urandom) : $urandom);
        set_thresholds(4'($urandom_range(0, hi)), 4'($urandom_range(0, hi)));
        wait_settle();
      end
    end
    clear_config();
    report_test("arbitration and thresholds", base);

    base = out_fails + rd_fails;
    set_thresholds('0, '0);
    write_reg(GWCFG_OFFS, 12, 32'h2);
    write_reg(PRIO_OFFS, 12, 32'd5);
    write_reg(ENABLE_OFFS, 12, 32'd1);
    drive_sources(NUM_SRC'(1) << 12);
    next_cycle();
    drive_sources('0);
    wait_settle();
    check_reg(PEND_OFFS, 0);
    wait_settle();
    check_reg(PEND_OFFS, 0);
    write_reg(GWCLR_OFFS, 12, '0);
    wait_settle();
    check_reg(PEND_OFFS, 0);
    clear_config();
    report_test("edge gateway", base);

    base = out_fails + rd_fails;
    write_reg(PRIO_OFFS, 20, 32'd3);
    write_reg(ENABLE_OFFS, 20, 32'd1);
    write_reg(GWCFG_OFFS, 20, 32'h1);   // Active low
    wait_settle();
    check_reg(PEND_OFFS, 0);
    drive_sources(NUM_SRC'(1) << 20);
    wait_settle();
    check_reg(PEND_OFFS, 0);
    drive_sources('0);
    wait_settle();
    clear_config();
    report_test("polarity", base);

    base = out_fails + rd_fails;
    write_reg(CONFIG_OFFS, 0, 32'd1);
    check_reg(CONFIG_OFFS, 0);
    set_thresholds(4'hf, 4'hf);
    write_reg(PRIO_OFFS, 3, 32'd4);
    write_reg(PRIO_OFFS, 25, 32'd7);
    foreach (cfg_prio[i]) if (i == 3 || i == 9 || i == 25) write_reg(ENABLE_OFFS, i, 32'd1);
    drive_sources((NUM_SRC'(1) << 3) | (NUM_SRC'(1) << 9) | (NUM_SRC'(1) << 25));
    wait_settle();
    set_thresholds(4'd5, 4'hf);
    wait_settle();
    drive_sources((NUM_SRC'(1) << 3) | (NUM_SRC'(1) << 25));
    wait_settle();
    set_thresholds(4'd4, 4'hf);   // Equal to the winner, no interrupt
    wait_settle();
    set_thresholds(4'hf, 4'd3);
    wait_settle();
    write_reg(CONFIG_OFFS, 0, '0);
    set_thresholds('0, '0);
    write_reg(PRIO_OFFS, 25, 32'd15);
    wait_settle();
    clear_config();
    report_test("reversed order and wake-up", base);

    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
             out_fails + rd_fails);
    if (tests_failed == 0 && out_fails + rd_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/pic_pkg.sv
hdl/pic_cfg_if.sv
hdl/pic_reg_decode.sv
hdl/pic_reg_file.sv
hdl/pic_gateway.sv
hdl/pic_priority_tree.sv
hdl/pic_claim.sv
hdl/pic_ctrl.sv
dv/pic_tb_clkgen.sv
dv/pic_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the interrupt controller testbench

TOP := pic_ctrl_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard hdl/*.sv dv/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module pic_ctrl

clean:
	rm -rf obj_dir sim.log
